// ==== files.f ====
verilog/id_pkg.sv
verilog/id_stage_reg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f files.f --top-module tb_id_stage -o sim_id_stage

out=$(./obj_dir/sim_id_stage) || true
echo "$out"
grep -q "TEST PASSED" <<< "$out"

// ==== tests/tb_id_stage.sv ====
module tb_id_stage;
    import id_pkg::*;

    localparam int PERIOD      = 100;
    localparam int TEST_CYCLES = 100;  // rough length of all tests together

    logic              clk = 1'b0;
    logic              resetn;
    logic              if_valid;
    logic [XLEN-1:0]   if_pc;
    logic [XLEN-1:0]   if_inst;
    logic              allow_in;
    logic              br_cancel;
    logic [XLEN-1:0]   br_target;
    logic              exe_allow_in;
    logic              to_exe_valid;
    logic [ALU_OPS-1:0] alu_op;
    logic [XLEN-1:0]   alu_src1;
    logic [XLEN-1:0]   alu_src2;
    logic              res_from_mem;
    logic              gr_we;
    logic              mem_we;
    logic [REG_AW-1:0] dest;
    logic [XLEN-1:0]   rkd_value;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    logic              exe_write;
    logic              exe_load;
    logic [REG_AW-1:0] exe_dest;
    logic [XLEN-1:0]   exe_result;
    logic              mem_write;
    logic [REG_AW-1:0] mem_dest;
    logic [XLEN-1:0]   mem_result;
    logic              wb_we;
    logic [REG_AW-1:0] wb_dest;
    logic [XLEN-1:0]   wb_data;

    logic [XLEN-1:0] regs [NREG];  // what was written through wb
    integer seed = 32'h142d_2b2b;

    id_stage uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    // instruction formats, fields as in the ISA manual
    function automatic logic [31:0] rrr_word(input logic [4:0] op5, input logic [4:0] rk,
                                             input logic [4:0] rj, input logic [4:0] rd);
        rrr_word = {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op10, input logic [11:0] i12,
                                              input logic [4:0] rj, input logic [4:0] rd);
        ri12_word = {op10, i12, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_word(input logic [5:0] op6, input logic [19:0] i20,
                                              input logic [4:0] rd);
        ri20_word = {op6, 1'b0, i20, rd};
    endfunction

    function automatic logic [31:0] ri16_word(input logic [5:0] op6, input logic [15:0] i16,
                                              input logic [4:0] rj, input logic [4:0] rd);
        ri16_word = {op6, i16, rj, rd};
    endfunction

    function automatic logic [31:0] i26_word(input logic [5:0] op6, input logic [25:0] offs);
        i26_word = {op6, offs[15:0], offs[25:16]};  // high offset bits go low
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        compare({31'b0, got}, {31'b0, exp}, what);
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [31:0] val);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_dest <= r;
        wb_data <= val;
        @(posedge clk);
        wb_we   <= 1'b0;
        regs[r] = val;
    endtask

    // offer one instruction, return at the negedge after it was taken
    task automatic issue(input logic [31:0] addr, input logic [31:0] word);
        @(posedge clk);
        if_valid <= 1'b1;
        if_pc    <= addr;
        if_inst  <= word;
        @(negedge clk);
        while (!allow_in) @(negedge clk);
        @(posedge clk);
        if_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic verify_alu(input logic [31:0] src1, input logic [31:0] src2,
                              input int op_bit, input logic [4:0] dst);
        compare(alu_src1, src1, "alu_src1");
        compare(alu_src2, src2, "alu_src2");
        compare({20'b0, alu_op}, 32'd1 << op_bit, "alu_op");
        compare({27'b0, dest}, {27'b0, dst}, "dest");
        compare_bit(gr_we, 1'b1, "gr_we");
        compare_bit(to_exe_valid, 1'b1, "to_exe_valid");
    endtask

    task automatic verify_branch(input logic taken, input logic [31:0] target);
        compare_bit(br_cancel, taken, "br_cancel");
        if (taken) begin
            compare(br_target, target, "br_target");
        end
    endtask

    task automatic reset_dut();
        resetn <= 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compare_bit(allow_in, 1'b1, "allow_in after reset");
        compare_bit(to_exe_valid, 1'b0, "to_exe_valid after reset");
        compare_bit(br_cancel, 1'b0, "br_cancel after reset");
    endtask

    task automatic decode_alu_ops();
        logic [31:0] base;
        base = 32'h1c00_0000;
        write_reg(5'd5, $random(seed));
        write_reg(5'd6, $random(seed));
        issue(base, rrr_word(5'h00, 5'd6, 5'd5, 5'd7));  // add.w r7, r5, r6
        verify_alu(regs[5], regs[6], ALU_ADD, 5'd7);
        issue(base + 4, ri12_word(10'h00a, 12'hffd, 5'd5, 5'd8));  // addi.w r8, r5, -3
        verify_alu(regs[5], 32'hffff_fffd, ALU_ADD, 5'd8);
        issue(base + 8, ri12_word(10'h00d, 12'h8a5, 5'd6, 5'd9));  // andi, zero-extended
        verify_alu(regs[6], 32'h0000_08a5, ALU_AND, 5'd9);
        // lu12i.w r10, the rj field falls on i20[4:0] = r5
        issue(base + 12, ri20_word(6'h05, 20'h12345, 5'd10));
        verify_alu(regs[5], 32'h1234_5000, ALU_LUI, 5'd10);
        issue(base + 16, ri20_word(6'h07, 20'h00abc, 5'd11));  // pcaddu12i r11
        verify_alu(base + 16, 32'h00ab_c000, ALU_ADD, 5'd11);
    endtask

    task automatic forward_priority();
        logic [31:0] e;
        logic [31:0] m;
        logic [31:0] w2;
        e  = $random(seed);
        m  = $random(seed);
        w2 = $random(seed);
        @(posedge clk);
        exe_allow_in <= 1'b0;  // hold the instruction in the stage
        exe_write    <= 1'b1;
        exe_dest     <= 5'd5;
        exe_result   <= e;
        mem_write    <= 1'b1;
        mem_dest     <= 5'd5;
        mem_result   <= m;
        wb_we        <= 1'b1;
        wb_dest      <= 5'd5;
        wb_data      <= $random(seed);
        issue(32'h1c00_0100, rrr_word(5'h00, 5'd0, 5'd5, 5'd7));  // add.w r7, r5, r0
        compare(alu_src1, e, "rj from exe");
        compare(rkd_value, 32'd0, "r0 source");
        @(posedge clk);
        exe_write <= 1'b0;
        @(negedge clk);
        compare(alu_src1, m, "rj from mem");
        @(posedge clk);
        mem_write <= 1'b0;
        wb_data   <= w2;  // differs from what the rf already took
        @(negedge clk);
        compare(alu_src1, w2, "rj from wb");
        @(posedge clk);
        wb_we   <= 1'b0;
        regs[5] = w2;
        @(negedge clk);
        compare(alu_src1, regs[5], "rj from regfile");
        @(posedge clk);
        exe_write <= 1'b1;  // producers naming r0
        exe_dest  <= 5'd0;
        mem_write <= 1'b1;
        mem_dest  <= 5'd0;
        @(negedge clk);
        compare(rkd_value, 32'd0, "r0 with producers on r0");
        compare(alu_src1, regs[5], "rj with producers on r0");
        @(posedge clk);
        exe_write    <= 1'b0;
        mem_write    <= 1'b0;
        exe_allow_in <= 1'b1;
        @(negedge clk);
    endtask

    task automatic stall_and_hold();
        logic [31:0] e;
        logic [31:0] word;
        logic [31:0] next_word;
        e         = $random(seed);
        word      = rrr_word(5'h00, 5'd6, 5'd5, 5'd7);
        next_word = rrr_word(5'h0a, 5'd6, 5'd5, 5'd9);  // or r9, r5, r6
        @(posedge clk);
        exe_write  <= 1'b1;
        exe_load   <= 1'b1;
        exe_dest   <= 5'd5;
        exe_result <= e;
        issue(32'h1c00_0200, word);
        compare_bit(to_exe_valid, 1'b0, "to_exe_valid on load-use");
        compare_bit(allow_in, 1'b0, "allow_in on load-use");
        @(posedge clk);
        if_valid <= 1'b1;  // next inst waits behind the stall
        if_pc    <= 32'h1c00_0204;
        if_inst  <= next_word;
        @(negedge clk);
        compare_bit(to_exe_valid, 1'b0, "to_exe_valid still stalled");
        @(posedge clk);
        exe_load     <= 1'b0;  // load result now forwardable
        exe_allow_in <= 1'b0;
        @(negedge clk);
        compare(pc, 32'h1c00_0200, "pc under stall");
        compare(inst, word, "inst under stall");
        compare_bit(to_exe_valid, 1'b1, "to_exe_valid after stall");
        compare_bit(allow_in, 1'b0, "allow_in under back-pressure");
        compare(alu_src1, e, "forwarded load result");
        compare(alu_src2, regs[6], "alu_src2 after stall");
        @(negedge clk);
        compare(pc, 32'h1c00_0200, "pc under back-pressure");
        compare(inst, word, "inst under back-pressure");
        @(posedge clk);
        exe_allow_in <= 1'b1;
        @(negedge clk);
        compare_bit(allow_in, 1'b1, "allow_in after release");
        @(posedge clk);
        if_valid  <= 1'b0;
        exe_write <= 1'b0;
        @(negedge clk);
        compare(pc, 32'h1c00_0204, "next pc taken in");
        compare(inst, next_word, "next inst taken in");
    endtask

    task automatic resolve_branches();
        logic [31:0] pb;
        pb = 32'h1c00_0300;
        write_reg(5'd12, $random(seed) | 32'h8000_0000);  // negative
        write_reg(5'd13, $random(seed) & 32'h7fff_ffff);  // positive
        issue(pb, ri16_word(6'h16, 16'h0020, 5'd12, 5'd12));  // beq taken
        verify_branch(1'b1, pb + 32'h80);
        @(negedge clk);
        compare_bit(to_exe_valid, 1'b0, "stage empty after cancel");
        issue(pb + 4, ri16_word(6'h16, 16'h0020, 5'd12, 5'd13));  // beq not taken
        verify_branch(1'b0, 32'd0);
        issue(pb + 8, ri16_word(6'h17, 16'h0020, 5'd12, 5'd13));  // bne taken
        verify_branch(1'b1, pb + 8 + 32'h80);
        issue(pb + 12, ri16_word(6'h17, 16'h0020, 5'd12, 5'd12));  // bne not taken
        verify_branch(1'b0, 32'd0);
        issue(pb + 16, ri16_word(6'h18, 16'hfff0, 5'd12, 5'd13));  // blt, neg < pos
        verify_branch(1'b1, pb + 16 - 32'h40);
        issue(pb + 20, ri16_word(6'h1a, 16'hfff0, 5'd12, 5'd13));  // bltu, neg is large
        verify_branch(1'b0, 32'd0);
        issue(pb + 24, ri16_word(6'h13, 16'hfff8, 5'd12, 5'd1));  // jirl r1, r12, -8
        verify_branch(1'b1, regs[12] - 32'd32);
        issue(pb + 28, i26_word(6'h15, 26'h3ff_ff00));  // bl -0x400
        verify_branch(1'b1, pb + 28 - 32'h400);
        verify_alu(pb + 28, 32'd4, ALU_ADD, RA_REG);
        // taken branch with the next fetch offered right behind it
        @(posedge clk);
        if_valid <= 1'b1;
        if_pc    <= pb + 32'h40;
        if_inst  <= ri16_word(6'h16, 16'h0020, 5'd12, 5'd12);
        @(posedge clk);
        if_pc    <= pb + 32'h44;
        if_inst  <= rrr_word(5'h00, 5'd6, 5'd5, 5'd7);
        @(negedge clk);
        verify_branch(1'b1, pb + 32'hc0);
        @(posedge clk);
        if_valid <= 1'b0;
        @(negedge clk);
        compare_bit(to_exe_valid, 1'b1, "offered inst after branch");
        compare(pc, pb + 32'h44, "pc after branch");
    endtask

    task automatic decode_mem_ops();
        issue(32'h1c00_0400, ri12_word(10'h0a5, 12'h7fe, 5'd12, 5'd13));  // st.h r13
        compare_bit(mem_we, 1'b1, "st.h mem_we");
        compare_bit(gr_we, 1'b0, "st.h gr_we");
        compare(rkd_value, regs[13], "st.h store data");
        compare(alu_src1, regs[12], "st.h base");
        compare(alu_src2, 32'h0000_07fe, "st.h offset");
        issue(32'h1c00_0404, ri12_word(10'h0a8, 12'hf00, 5'd12, 5'd14));  // ld.bu r14
        compare_bit(res_from_mem, 1'b1, "ld.bu res_from_mem");
        compare_bit(mem_we, 1'b0, "ld.bu mem_we");
        compare_bit(gr_we, 1'b1, "ld.bu gr_we");
        compare(alu_src2, 32'hffff_ff00, "ld.bu offset");
        compare({27'b0, dest}, 32'd14, "ld.bu dest");
    endtask

    initial begin
        resetn       <= 1'b0;
        if_valid     <= 1'b0;
        if_pc        <= '0;
        if_inst      <= '0;
        exe_allow_in <= 1'b1;
        exe_write    <= 1'b0;
        exe_load     <= 1'b0;
        exe_dest     <= '0;
        exe_result   <= '0;
        mem_write    <= 1'b0;
        mem_dest     <= '0;
        mem_result   <= '0;
        wb_we        <= 1'b0;
        wb_dest      <= '0;
        wb_data      <= '0;
        reset_dut();
        decode_alu_ops();
        forward_priority();
        stall_and_hold();
        resolve_branches();
        decode_mem_ops();
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(4 * TEST_CYCLES * PERIOD);
        $display("watchdog expired, the tests did not finish");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== verilog/branch_unit.sv ====
module branch_unit (
    input  logic [id_pkg::BR_KW-1:0] br_kind,
    input  logic [id_pkg::XLEN-1:0]  rj_value,
    input  logic [id_pkg::XLEN-1:0]  rkd_value,
    input  logic [id_pkg::XLEN-1:0]  pc,
    input  logic [id_pkg::XLEN-1:0]  br_offs,
    input  logic [id_pkg::XLEN-1:0]  jirl_offs,
    output logic                     br_taken,
    output logic [id_pkg::XLEN-1:0]  br_target
);
    import id_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            BR_B, BR_BL, BR_JIRL: br_taken = 1'b1;
            BR_BEQ:  br_taken = eq;
            BR_BNE:  br_taken = !eq;
            BR_BLT:  br_taken = lt;
            BR_BGE:  br_taken = !lt;
            BR_BLTU: br_taken = ltu;
            BR_BGEU: br_taken = !ltu;
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = (br_kind == BR_JIRL) ? rj_value + jirl_offs : pc + br_offs;

endmodule

// ==== verilog/id_pkg.sv ====
package id_pkg;

    localparam int XLEN    = 32;
    localparam int NREG    = 32;
    localparam int REG_AW  = 5;
    localparam int ALU_OPS = 12;
    localparam int BR_KW   = 4;

    // one-hot alu op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [REG_AW-1:0] RA_REG = 5'd1;  // link reg for bl

    localparam logic [BR_KW-1:0] BR_NONE = 4'd0;
    localparam logic [BR_KW-1:0] BR_B    = 4'd1;
    localparam logic [BR_KW-1:0] BR_BL   = 4'd2;
    localparam logic [BR_KW-1:0] BR_JIRL = 4'd3;
    localparam logic [BR_KW-1:0] BR_BEQ  = 4'd4;
    localparam logic [BR_KW-1:0] BR_BNE  = 4'd5;
    localparam logic [BR_KW-1:0] BR_BLT  = 4'd6;
    localparam logic [BR_KW-1:0] BR_BGE  = 4'd7;
    localparam logic [BR_KW-1:0] BR_BLTU = 4'd8;
    localparam logic [BR_KW-1:0] BR_BGEU = 4'd9;

    // inst[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // inst[25:22] under OP6_ALU
    localparam logic [3:0] OP4_3R     = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // inst[25:22] under OP6_MEM
    localparam logic [3:0] OP4_LD_B  = 4'h0;
    localparam logic [3:0] OP4_LD_H  = 4'h1;
    localparam logic [3:0] OP4_LD_W  = 4'h2;
    localparam logic [3:0] OP4_ST_B  = 4'h4;
    localparam logic [3:0] OP4_ST_H  = 4'h5;
    localparam logic [3:0] OP4_ST_W  = 4'h6;
    localparam logic [3:0] OP4_LD_BU = 4'h8;
    localparam logic [3:0] OP4_LD_HU = 4'h9;

endpackage

// ==== verilog/id_stage.sv ====
module id_stage (
    input  logic                       clk,
    input  logic                       resetn,
    // fetch
    input  logic                       if_valid,
    input  logic [id_pkg::XLEN-1:0]    if_pc,
    input  logic [id_pkg::XLEN-1:0]    if_inst,
    output logic                       allow_in,
    output logic                       br_cancel,
    output logic [id_pkg::XLEN-1:0]    br_target,
    // execute
    input  logic                       exe_allow_in,
    output logic                       to_exe_valid,
    output logic [id_pkg::ALU_OPS-1:0] alu_op,
    output logic [id_pkg::XLEN-1:0]    alu_src1,
    output logic [id_pkg::XLEN-1:0]    alu_src2,
    output logic                       res_from_mem,
    output logic                       gr_we,
    output logic                       mem_we,
    output logic [id_pkg::REG_AW-1:0]  dest,
    output logic [id_pkg::XLEN-1:0]    rkd_value,
    output logic [id_pkg::XLEN-1:0]    pc,
    output logic [id_pkg::XLEN-1:0]    inst,
    // bypass sources
    input  logic                       exe_write,
    input  logic                       exe_load,
    input  logic [id_pkg::REG_AW-1:0]  exe_dest,
    input  logic [id_pkg::XLEN-1:0]    exe_result,
    input  logic                       mem_write,
    input  logic [id_pkg::REG_AW-1:0]  mem_dest,
    input  logic [id_pkg::XLEN-1:0]    mem_result,
    input  logic                       wb_we,
    input  logic [id_pkg::REG_AW-1:0]  wb_dest,
    input  logic [id_pkg::XLEN-1:0]    wb_data
);
    import id_pkg::*;

    logic              valid;
    logic              load_use_stall;
    logic              br_taken;
    logic [XLEN-1:0]   imm;
    logic              src1_is_pc;
    logic              src2_is_imm;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rkd;
    logic              rj_used;
    logic              rkd_used;
    logic [BR_KW-1:0]  br_kind;
    logic [XLEN-1:0]   br_offs;
    logic [XLEN-1:0]   jirl_offs;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic [XLEN-1:0]   rj_value;

    id_stage_reg u_stage_reg (.*);

    inst_decoder u_decoder (.*);

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rkd),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_dest),
        .wdata  (wb_data)
    );

    operand_forward u_forward (.*);

    branch_unit u_branch (.*);

endmodule

// ==== verilog/id_stage_reg.sv ====
module id_stage_reg (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    if_valid,
    input  logic [id_pkg::XLEN-1:0] if_pc,
    input  logic [id_pkg::XLEN-1:0] if_inst,
    input  logic                    exe_allow_in,
    input  logic                    load_use_stall,
    input  logic                    br_taken,
    output logic                    allow_in,
    output logic                    to_exe_valid,
    output logic                    br_cancel,
    output logic                    valid,
    output logic [id_pkg::XLEN-1:0] pc,
    output logic [id_pkg::XLEN-1:0] inst
);
    logic ready_go;

    assign ready_go     = ~load_use_stall;
    assign allow_in     = ~valid | (ready_go & exe_allow_in);
    assign to_exe_valid = valid & ready_go;
    assign br_cancel    = valid & br_taken & ready_go;  // redirect to fetch

    // a taken branch leaving with no new instruction empties the stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && allow_in) begin
            pc   <= if_pc;
            inst <= if_inst;
        end
    end

    // cancelled branch does not reappear toward execute
    assert property (@(posedge clk) disable iff (!resetn)
        br_cancel && allow_in && !if_valid |=> !to_exe_valid);

    // held instruction stays put under stall or back-pressure
    assert property (@(posedge clk) disable iff (!resetn)
        !allow_in |=> valid && $stable(pc) && $stable(inst));

endmodule

// ==== verilog/inst_decoder.sv ====
module inst_decoder (
    input  logic [id_pkg::XLEN-1:0]    inst,
    output logic [id_pkg::ALU_OPS-1:0] alu_op,
    output logic [id_pkg::XLEN-1:0]    imm,
    output logic                       src1_is_pc,
    output logic                       src2_is_imm,
    output logic                       res_from_mem,
    output logic                       gr_we,
    output logic                       mem_we,
    output logic [id_pkg::REG_AW-1:0]  dest,
    output logic [id_pkg::REG_AW-1:0]  rj,
    output logic [id_pkg::REG_AW-1:0]  rkd,
    output logic                       rj_used,
    output logic                       rkd_used,
    output logic [id_pkg::BR_KW-1:0]   br_kind,
    output logic [id_pkg::XLEN-1:0]    br_offs,
    output logic [id_pkg::XLEN-1:0]    jirl_offs
);
    import id_pkg::*;

    logic [5:0]        op6;
    logic [3:0]        op4;
    logic [1:0]        op2;
    logic [4:0]        op5;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rk;
    logic [11:0]       i12;
    logic [15:0]       i16;
    logic [19:0]       i20;
    logic [25:0]       i26;
    logic is_alu, is_3r, is_shi, is_mem, is_rr, is_load, is_store, is_cbr;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w, inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i, inst_jirl, inst_b, inst_bl;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic link, need_si20, need_zext;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};  // offs[25:16] sits in the low bits

    assign is_alu = op6 == OP6_ALU;
    assign is_3r  = is_alu && op4 == OP4_3R && op2 == 2'h1;
    assign is_shi = is_alu && op4 == OP4_SHIFTI && op2 == 2'h0;
    assign is_mem = op6 == OP6_MEM;

    assign inst_add_w     = is_3r && op5 == 5'h00;
    assign inst_sub_w     = is_3r && op5 == 5'h02;
    assign inst_slt       = is_3r && op5 == 5'h04;
    assign inst_sltu      = is_3r && op5 == 5'h05;
    assign inst_nor       = is_3r && op5 == 5'h08;
    assign inst_and       = is_3r && op5 == 5'h09;
    assign inst_or        = is_3r && op5 == 5'h0a;
    assign inst_xor       = is_3r && op5 == 5'h0b;
    assign inst_sll_w     = is_3r && op5 == 5'h0e;
    assign inst_srl_w     = is_3r && op5 == 5'h0f;
    assign inst_sra_w     = is_3r && op5 == 5'h10;
    assign inst_slli_w    = is_shi && op5 == 5'h01;
    assign inst_srli_w    = is_shi && op5 == 5'h09;
    assign inst_srai_w    = is_shi && op5 == 5'h11;
    assign inst_slti      = is_alu && op4 == OP4_SLTI;
    assign inst_sltui     = is_alu && op4 == OP4_SLTUI;
    assign inst_addi_w    = is_alu && op4 == OP4_ADDI;
    assign inst_andi      = is_alu && op4 == OP4_ANDI;
    assign inst_ori       = is_alu && op4 == OP4_ORI;
    assign inst_xori      = is_alu && op4 == OP4_XORI;
    assign inst_lu12i_w   = op6 == OP6_LU12I && !inst[25];
    assign inst_pcaddu12i = op6 == OP6_PCADDU12I && !inst[25];
    assign inst_ld_b      = is_mem && op4 == OP4_LD_B;
    assign inst_ld_h      = is_mem && op4 == OP4_LD_H;
    assign inst_ld_w      = is_mem && op4 == OP4_LD_W;
    assign inst_ld_bu     = is_mem && op4 == OP4_LD_BU;
    assign inst_ld_hu     = is_mem && op4 == OP4_LD_HU;
    assign inst_st_b      = is_mem && op4 == OP4_ST_B;
    assign inst_st_h      = is_mem && op4 == OP4_ST_H;
    assign inst_st_w      = is_mem && op4 == OP4_ST_W;
    assign inst_jirl      = op6 == OP6_JIRL;
    assign inst_b         = op6 == OP6_B;
    assign inst_bl        = op6 == OP6_BL;

    assign is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store = inst_st_b | inst_st_h | inst_st_w;
    assign is_cbr   = op6 inside {OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU};
    assign is_rr    = is_3r & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                    | inst_and | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w);

    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store | inst_jirl
                            | inst_bl | inst_pcaddu12i;  // address and link adds too
    assign alu_op[ALU_SUB]  = inst_sub_w;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[ALU_LUI]  = inst_lu12i_w;

    assign link      = inst_jirl | inst_bl;  // return address is pc + 4
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_zext = inst_andi | inst_ori | inst_xori;

    assign imm = link      ? XLEN'(4) :
                 need_si20 ? {i20, 12'b0} :
                 need_zext ? {{(XLEN-12){1'b0}}, i12} :
                             {{(XLEN-12){i12[11]}}, i12};

    assign br_offs   = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc   = link | inst_pcaddu12i;
    assign src2_is_imm  = (|alu_op) & ~is_rr;  // every non reg-reg alu user takes imm
    assign res_from_mem = is_load;
    assign mem_we       = is_store;
    assign gr_we        = (|alu_op) & ~is_store;
    assign dest         = inst_bl ? RA_REG : rd;

    assign rkd      = (is_store | is_cbr) ? rd : rk;
    assign rj_used  = ((|alu_op) & ~(inst_bl | inst_lu12i_w | inst_pcaddu12i)) | is_cbr;
    assign rkd_used = is_rr | is_store | is_cbr;

    always_comb begin
        case (op6)
            OP6_B:    br_kind = BR_B;
            OP6_BL:   br_kind = BR_BL;
            OP6_JIRL: br_kind = BR_JIRL;
            OP6_BEQ:  br_kind = BR_BEQ;
            OP6_BNE:  br_kind = BR_BNE;
            OP6_BLT:  br_kind = BR_BLT;
            OP6_BGE:  br_kind = BR_BGE;
            OP6_BLTU: br_kind = BR_BLTU;
            OP6_BGEU: br_kind = BR_BGEU;
            default:  br_kind = BR_NONE;
        endcase
    end

    // the match terms above must stay mutually exclusive
    always_comb begin
        assert final ($onehot0(alu_op));
    end

endmodule

// ==== verilog/operand_forward.sv ====
module operand_forward (
    input  logic [id_pkg::REG_AW-1:0] rj,
    input  logic [id_pkg::REG_AW-1:0] rkd,
    input  logic                      rj_used,
    input  logic                      rkd_used,
    input  logic [id_pkg::XLEN-1:0]   rf_rdata1,
    input  logic [id_pkg::XLEN-1:0]   rf_rdata2,
    input  logic                      exe_write,
    input  logic                      exe_load,
    input  logic [id_pkg::REG_AW-1:0] exe_dest,
    input  logic [id_pkg::XLEN-1:0]   exe_result,
    input  logic                      mem_write,
    input  logic [id_pkg::REG_AW-1:0] mem_dest,
    input  logic [id_pkg::XLEN-1:0]   mem_result,
    input  logic                      wb_we,
    input  logic [id_pkg::REG_AW-1:0] wb_dest,
    input  logic [id_pkg::XLEN-1:0]   wb_data,
    input  logic [id_pkg::XLEN-1:0]   pc,
    input  logic [id_pkg::XLEN-1:0]   imm,
    input  logic                      src1_is_pc,
    input  logic                      src2_is_imm,
    output logic [id_pkg::XLEN-1:0]   rj_value,
    output logic [id_pkg::XLEN-1:0]   rkd_value,
    output logic [id_pkg::XLEN-1:0]   alu_src1,
    output logic [id_pkg::XLEN-1:0]   alu_src2,
    output logic                      load_use_stall
);
    import id_pkg::*;

    // youngest producer wins, r0 never forwarded
    function automatic logic [XLEN-1:0] pick(input logic [REG_AW-1:0] r,
                                             input logic [XLEN-1:0]   rf_val);
        logic live;
        live = r != '0;
        if (live && exe_write && exe_dest == r) begin
            pick = exe_result;
        end else if (live && mem_write && mem_dest == r) begin
            pick = mem_result;
        end else if (live && wb_we && wb_dest == r) begin
            pick = wb_data;  // same-cycle rf write
        end else begin
            pick = rf_val;
        end
    endfunction

    always_comb begin
        rj_value  = pick(rj, rf_rdata1);
        rkd_value = pick(rkd, rf_rdata2);
    end

    // load result not ready until mem
    assign load_use_stall = exe_load && exe_dest != '0
                          && ((rj_used && exe_dest == rj) || (rkd_used && exe_dest == rkd));

    assign alu_src1 = src1_is_pc  ? pc  : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

endmodule

// ==== verilog/regfile.sv ====
module regfile (
    input  logic                      clk,
    input  logic [id_pkg::REG_AW-1:0] raddr1,
    output logic [id_pkg::XLEN-1:0]   rdata1,
    input  logic [id_pkg::REG_AW-1:0] raddr2,
    output logic [id_pkg::XLEN-1:0]   rdata2,
    input  logic                      we,
    input  logic [id_pkg::REG_AW-1:0] waddr,
    input  logic [id_pkg::XLEN-1:0]   wdata
);
    import id_pkg::*;

    logic [XLEN-1:0] rf [NREG];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule
